// ==== hdl/event_pkg.sv ====
`default_nettype none

package event_pkg;

    // link geometry and bus widths
    localparam int NUM_LINKS = 4;
    localparam int LINK_DW   = 32;
    localparam int EVNUM_W   = 16;
    localparam int APB_AW    = 8;

    // one word on a link or on the event output
    typedef struct packed {
        logic [LINK_DW-1:0] tdata;
        logic               tlast;
    } link_beat_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [31:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        RD_IDLE   = 2'd0,
        RD_HEADER = 2'd1,
        RD_LINK   = 2'd2
    } rd_state_t;

    // register map, byte addresses
    typedef enum logic [APB_AW-1:0] {
        REG_MASK    = 8'h00,
        REG_EVENTS  = 8'h04,
        REG_DROPPED = 8'h08
    } reg_addr_t;

endpackage

`default_nettype wire

// ==== hdl/event_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module event_regs (
    input  wire                              aclk,
    input  wire                              arst_n_i,
    input  wire event_pkg::apb_req_t         apb_i,
    output event_pkg::apb_rsp_t              apb_o,
    input  wire [event_pkg::NUM_LINKS-1:0]   drop_i,
    input  wire [event_pkg::EVNUM_W-1:0]     event_count_i,
    output logic [event_pkg::NUM_LINKS-1:0]  tio_mask_o
);

    localparam int CNT_W = $clog2(event_pkg::NUM_LINKS + 1);

    logic                 access;
    event_pkg::reg_addr_t addr;
    logic                 addr_hit;
    logic [31:0]          rdata;
    logic [CNT_W-1:0]     drop_sum;
    logic [16:0]          dropped_next;
    logic [15:0]          dropped_q;

    // access phase of a zero-wait transfer
    assign access = apb_i.psel & apb_i.penable;
    assign addr   = event_pkg::reg_addr_t'(apb_i.paddr);

    // how many links threw a word away this cycle
    always_comb begin
        drop_sum = '0;
        for (int i = 0; i < event_pkg::NUM_LINKS; i++) begin
            drop_sum = drop_sum + CNT_W'(drop_i[i]);
        end
    end

    assign dropped_next = {1'b0, dropped_q} + 17'(drop_sum);

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tio_mask_o <= '0;
            dropped_q  <= '0;
        end else begin
            if (access && apb_i.pwrite && addr == event_pkg::REG_MASK) begin
                tio_mask_o <= apb_i.pwdata[event_pkg::NUM_LINKS-1:0];
            end
            // counter sticks at all ones
            if (dropped_next[16]) begin
                dropped_q <= 16'hffff;
            end else begin
                dropped_q <= dropped_next[15:0];
            end
        end
    end

    // read mux
    always_comb begin
        addr_hit = 1'b1;
        case (addr)
            event_pkg::REG_MASK:    rdata = 32'(tio_mask_o);
            event_pkg::REG_EVENTS:  rdata = 32'(event_count_i);
            event_pkg::REG_DROPPED: rdata = 32'(dropped_q);
            default: begin
                addr_hit = 1'b0;
                rdata    = '0;
            end
        endcase
    end

    always_comb begin
        apb_o.prdata  = rdata;
        apb_o.pready  = 1'b1;
        apb_o.pslverr = access & ~addr_hit;
    end

endmodule

`default_nettype wire

// ==== hdl/link_accumulator.sv ====
`timescale 1ns/100ps
`default_nettype none

module link_accumulator #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                         aclk,
    input  wire                         arst_n_i,
    input  wire                         s_valid_i,
    input  wire event_pkg::link_beat_t  s_beat_i,
    output logic                        s_ready_o,
    input  wire                         accept_i,
    output event_pkg::link_beat_t       head_o,
    output logic                        head_valid_o,
    input  wire                         pop_i,
    output logic                        drop_o,
    output logic                        share_done_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    // circular word buffer, one extra pointer bit tells full from empty
    event_pkg::link_beat_t mem [FIFO_DEPTH];
    logic [AW:0]           wr_ptr_q;
    logic [AW:0]           rd_ptr_q;
    logic                  full;
    logic                  empty;
    logic                  push;
    logic                  pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    // closed link swallows everything, open link pushes back when full
    assign s_ready_o = accept_i ? ~full : 1'b1;
    assign push      = s_valid_i & accept_i & ~full;
    assign drop_o    = s_valid_i & ~accept_i;

    // share ends on an accepted last word
    assign share_done_o = push & s_beat_i.tlast;

    assign pop          = pop_i & ~empty;
    assign head_o       = mem[rd_ptr_q[AW-1:0]];
    assign head_valid_o = ~empty;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr_q[AW-1:0]] <= s_beat_i;
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/completion_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module completion_tracker (
    input  wire                              aclk,
    input  wire                              arst_n_i,
    input  wire                              event_open_i,
    input  wire [event_pkg::NUM_LINKS-1:0]   tio_mask_i,
    input  wire [event_pkg::NUM_LINKS-1:0]   share_done_i,
    input  wire [event_pkg::NUM_LINKS-1:0]   retire_i,
    output logic [event_pkg::NUM_LINKS-1:0]  accept_o,
    output logic                             event_ready_o
);

    // pending shares are bounded by the buffer depth
    localparam int PEND_W = 16;

    logic [PEND_W-1:0]               pend_q [event_pkg::NUM_LINKS];
    logic [event_pkg::NUM_LINKS-1:0] has_pend;

    assign accept_o = {event_pkg::NUM_LINKS{event_open_i}} & ~tio_mask_i;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < event_pkg::NUM_LINKS; i++) begin
                pend_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < event_pkg::NUM_LINKS; i++) begin
                // done and retire together leave the count alone
                if (share_done_i[i] && !retire_i[i]) begin
                    pend_q[i] <= pend_q[i] + 1'b1;
                end else if (!share_done_i[i] && retire_i[i]) begin
                    pend_q[i] <= pend_q[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < event_pkg::NUM_LINKS; i++) begin
            has_pend[i] = (pend_q[i] != '0);
        end
    end

    // masked links never hold up an event, but one link must be live
    assign event_ready_o = (|(~tio_mask_i)) & (&(has_pend | tio_mask_i));

endmodule

`default_nettype wire

// ==== hdl/event_readout.sv ====
`timescale 1ns/100ps
`default_nettype none

module event_readout (
    input  wire                              aclk,
    input  wire                              arst_n_i,
    input  wire                              event_ready_i,
    input  wire [event_pkg::NUM_LINKS-1:0]   tio_mask_i,
    input  wire event_pkg::link_beat_t       head_i [event_pkg::NUM_LINKS],
    input  wire [event_pkg::NUM_LINKS-1:0]   head_valid_i,
    output logic [event_pkg::NUM_LINKS-1:0]  pop_o,
    output logic [event_pkg::NUM_LINKS-1:0]  retire_o,
    output event_pkg::link_beat_t            m_beat_o,
    output logic                             m_valid_o,
    input  wire                              m_ready_i,
    output logic [event_pkg::EVNUM_W-1:0]    event_count_o
);

    localparam int LW = $clog2(event_pkg::NUM_LINKS);

    event_pkg::rd_state_t            state_q;
    logic [event_pkg::NUM_LINKS-1:0] active_q;
    logic [LW-1:0]                   cur_q;
    logic [LW-1:0]                   first_link;
    logic [LW-1:0]                   next_link;
    logic                            last_link;
    logic                            link_xfer;
    logic                            share_end;
    event_pkg::link_beat_t           cur_head;

    // lowest active link, and the next active one above the current link
    always_comb begin
        first_link = '0;
        next_link  = cur_q;
        last_link  = 1'b1;
        for (int i = event_pkg::NUM_LINKS - 1; i >= 0; i--) begin
            if (active_q[i]) begin
                first_link = LW'(i);
                if (i > int'(cur_q)) begin
                    next_link = LW'(i);
                    last_link = 1'b0;
                end
            end
        end
    end

    assign cur_head  = head_i[cur_q];
    assign link_xfer = (state_q == event_pkg::RD_LINK) & head_valid_i[cur_q] & m_ready_i;
    assign share_end = link_xfer & cur_head.tlast;

    // output mux, header word or the head of the current link
    always_comb begin
        m_valid_o = 1'b0;
        m_beat_o  = '0;
        pop_o     = '0;
        retire_o  = '0;
        case (state_q)
            event_pkg::RD_HEADER: begin
                m_valid_o      = 1'b1;
                m_beat_o.tdata = event_pkg::LINK_DW'({active_q, event_count_o});
            end
            event_pkg::RD_LINK: begin
                m_valid_o      = head_valid_i[cur_q];
                m_beat_o.tdata = cur_head.tdata;
                // only the final active link closes the event
                m_beat_o.tlast = cur_head.tlast & last_link;
                pop_o[cur_q]    = link_xfer;
                retire_o[cur_q] = share_end;
            end
            default: begin
                m_valid_o = 1'b0;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= event_pkg::RD_IDLE;
            active_q      <= '0;
            cur_q         <= '0;
            event_count_o <= '0;
        end else begin
            case (state_q)
                event_pkg::RD_IDLE: begin
                    if (event_ready_i) begin
                        active_q <= ~tio_mask_i;
                        state_q  <= event_pkg::RD_HEADER;
                    end
                end
                event_pkg::RD_HEADER: begin
                    if (m_ready_i) begin
                        cur_q   <= first_link;
                        state_q <= event_pkg::RD_LINK;
                    end
                end
                event_pkg::RD_LINK: begin
                    if (share_end && last_link) begin
                        event_count_o <= event_count_o + 1'b1;
                        state_q       <= event_pkg::RD_IDLE;
                    end else if (share_end) begin
                        cur_q <= next_link;
                    end
                end
                default: begin
                    state_q <= event_pkg::RD_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/event_builder_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module event_builder_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                              aclk,
    input  wire                              arst_n_i,
    input  wire                              event_open_i,
    input  wire [event_pkg::NUM_LINKS-1:0]   s_link_valid_i,
    input  wire event_pkg::link_beat_t       s_link_beat_i [event_pkg::NUM_LINKS],
    output wire [event_pkg::NUM_LINKS-1:0]   s_link_ready_o,
    output wire event_pkg::link_beat_t       m_ev_beat_o,
    output wire                              m_ev_valid_o,
    input  wire                              m_ev_ready_i,
    output wire                              evin_ready_o,
    input  wire event_pkg::apb_req_t         apb_i,
    output wire event_pkg::apb_rsp_t         apb_o
);

    wire event_pkg::link_beat_t           acc_head [event_pkg::NUM_LINKS];
    wire [event_pkg::NUM_LINKS-1:0]       acc_head_valid;
    wire [event_pkg::NUM_LINKS-1:0]       acc_pop;
    wire [event_pkg::NUM_LINKS-1:0]       acc_drop;
    wire [event_pkg::NUM_LINKS-1:0]       acc_share_done;
    wire [event_pkg::NUM_LINKS-1:0]       link_accept;
    wire [event_pkg::NUM_LINKS-1:0]       link_retire;
    wire [event_pkg::NUM_LINKS-1:0]       tio_mask;
    wire [event_pkg::EVNUM_W-1:0]         event_count;

    // one buffer per link
    for (genvar i = 0; i < event_pkg::NUM_LINKS; i++) begin : g_link
        link_accumulator #(.FIFO_DEPTH(FIFO_DEPTH)) u_accum (
            .aclk         (aclk),
            .arst_n_i     (arst_n_i),
            .s_valid_i    (s_link_valid_i[i]),
            .s_beat_i     (s_link_beat_i[i]),
            .s_ready_o    (s_link_ready_o[i]),
            .accept_i     (link_accept[i]),
            .head_o       (acc_head[i]),
            .head_valid_o (acc_head_valid[i]),
            .pop_i        (acc_pop[i]),
            .drop_o       (acc_drop[i]),
            .share_done_o (acc_share_done[i])
        );
    end

    completion_tracker u_tracker (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .event_open_i  (event_open_i),
        .tio_mask_i    (tio_mask),
        .share_done_i  (acc_share_done),
        .retire_i      (link_retire),
        .accept_o      (link_accept),
        .event_ready_o (evin_ready_o)
    );

    event_readout u_readout (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .event_ready_i (evin_ready_o),
        .tio_mask_i    (tio_mask),
        .head_i        (acc_head),
        .head_valid_i  (acc_head_valid),
        .pop_o         (acc_pop),
        .retire_o      (link_retire),
        .m_beat_o      (m_ev_beat_o),
        .m_valid_o     (m_ev_valid_o),
        .m_ready_i     (m_ev_ready_i),
        .event_count_o (event_count)
    );

    event_regs u_registers (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .apb_i         (apb_i),
        .apb_o         (apb_o),
        .drop_i        (acc_drop),
        .event_count_i (event_count),
        .tio_mask_o    (tio_mask)
    );

endmodule

`default_nettype wire

// ==== verif/event_builder_tasks.svh ====
`ifndef EVENT_BUILDER_TASKS_SVH
`define EVENT_BUILDER_TASKS_SVH
`default_nettype none

// APB tasks start and return 2 ns after a rising edge
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    apb_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge aclk);
    #2;
    apb_i.penable = 1'b1;
    @(posedge aclk);
    #2;
    apb_i = '0;
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
    @(posedge aclk);
    #2;
    apb_i.penable = 1'b1;
    // response is settled mid-cycle in the access phase
    @(negedge aclk);
    data = apb_o.prdata;
    err  = apb_o.pslverr;
    // zero-wait slave
    expect_equal("apb_o.pready", 32'(apb_o.pready), 32'h1);
    @(posedge aclk);
    #2;
    apb_i = '0;
endtask

task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        $display("error: %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic expect_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    read_reg(addr, data, err);
    expect_equal(name, data, exp);
    expect_equal({name, " pslverr"}, 32'(err), 32'h0);
endtask

// random share on every link plus the output words the event must produce
task automatic build_event(input logic [3:0] mask);
    event_pkg::link_beat_t beat;
    int                    len;
    int                    last_live;
    beat.tdata = {12'h000, ~mask, ev_num};
    beat.tlast = 1'b0;
    exp_q.push_back(beat);
    last_live = 0;
    for (int l = 0; l < event_pkg::NUM_LINKS; l++) begin
        if (!mask[l]) begin
            last_live = l;
        end
    end
    for (int l = 0; l < event_pkg::NUM_LINKS; l++) begin
        len = $urandom_range(6, 1);
        for (int w = 0; w < len; w++) begin
            beat.tdata = $urandom;
            beat.tlast = (w == len - 1);
            link_q[l].push_back(beat);
            if (mask[l]) begin
                drop_exp++;
            end else begin
                // only the final live link closes the output event
                beat.tlast = beat.tlast && (l == last_live);
                exp_q.push_back(beat);
            end
        end
    end
    ev_num++;
endtask

// valid/ready source for one link that samples ready mid-cycle
task automatic drive_link(input int l);
    logic taken;
    while (link_q[l].size() != 0) begin
        s_link_beat_i[l]  = link_q[l].pop_front();
        s_link_valid_i[l] = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge aclk);
            taken = s_link_ready_o[l];
            @(posedge aclk);
            #2;
        end
    end
    s_link_valid_i[l] = 1'b0;
endtask

task automatic send_links();
    fork
        drive_link(0);
        drive_link(1);
        drive_link(2);
        drive_link(3);
    join
endtask

task automatic wait_drain();
    while (exp_q.size() != 0) begin
        @(posedge aclk);
        #2;
    end
endtask

task automatic run_events(input int num, input logic [3:0] mask);
    write_reg(event_pkg::REG_MASK, 32'(mask));
    event_open_i = 1'b1;
    for (int e = 0; e < num; e++) begin
        build_event(mask);
    end
    send_links();
    wait_drain();
    event_open_i = 1'b0;
endtask

`default_nettype wire
`endif

// ==== verif/event_builder_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module event_builder_tb;

    localparam int SEED = 32'hf3b2_9ed5;
    // about 7 events of at most 25 words each, so a wide margin
    localparam int MAX_CYCLES = 20000;

    logic                            aclk = 1'b0;
    logic                            arst_n_i;
    logic                            event_open_i;
    logic [event_pkg::NUM_LINKS-1:0] s_link_valid_i;
    event_pkg::link_beat_t           s_link_beat_i [event_pkg::NUM_LINKS];
    wire  [event_pkg::NUM_LINKS-1:0] s_link_ready_o;
    wire  event_pkg::link_beat_t     m_ev_beat_o;
    wire                             m_ev_valid_o;
    logic                            m_ev_ready_i;
    wire                             evin_ready_o;
    event_pkg::apb_req_t             apb_i;
    event_pkg::apb_rsp_t             apb_o;

    event_pkg::link_beat_t exp_q [$];
    event_pkg::link_beat_t link_q [event_pkg::NUM_LINKS][$];
    event_pkg::link_beat_t exp_beat;
    logic [15:0]           ev_num = '0;
    int                    drop_exp = 0;
    bit                    rand_ready = 1'b0;
    int                    errors = 0;
    int                    err_mark = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;
    int                    cycles = 0;
    string                 test_name;
    logic [31:0]           rdata;
    logic                  rerr;

    `include "event_builder_tasks.svh"

    event_builder_top #(.FIFO_DEPTH(16)) i_event_builder_top (
        .aclk           (aclk),
        .arst_n_i       (arst_n_i),
        .event_open_i   (event_open_i),
        .s_link_valid_i (s_link_valid_i),
        .s_link_beat_i  (s_link_beat_i),
        .s_link_ready_o (s_link_ready_o),
        .m_ev_beat_o    (m_ev_beat_o),
        .m_ev_valid_o   (m_ev_valid_o),
        .m_ev_ready_i   (m_ev_ready_i),
        .evin_ready_o   (evin_ready_o),
        .apb_i          (apb_i),
        .apb_o          (apb_o)
    );

    always #20 aclk = ~aclk;

    always @(posedge aclk) begin
        #2;
        m_ev_ready_i = rand_ready ? ($urandom_range(3, 0) != 0) : 1'b1;
    end

    // stalled output word must hold until taken
    hold_while_stalled: assert property (@(negedge aclk) disable iff (!arst_n_i)
        (m_ev_valid_o && !m_ev_ready_i) |=> (m_ev_valid_o && $stable(m_ev_beat_o)))
    else begin
        $display("output word changed while ready was held low");
        errors++;
    end

    // output scoreboard, every handshake takes the next word of the model queue
    always @(negedge aclk) begin
        if (arst_n_i && m_ev_valid_o) begin
            assert (exp_q.size() != 0) else begin
                $display("output valid with no event expected, data %h", m_ev_beat_o.tdata);
                errors++;
            end
        end
        if (arst_n_i && m_ev_valid_o && m_ev_ready_i && exp_q.size() != 0) begin
            exp_beat = exp_q.pop_front();
            expect_equal("m_ev_beat_o.tdata", m_ev_beat_o.tdata, exp_beat.tdata);
            expect_equal("m_ev_beat_o.tlast", 32'(m_ev_beat_o.tlast), 32'(exp_beat.tlast));
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic finish_test();
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - err_mark);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n_i       = 1'b0;
        event_open_i   = 1'b0;
        s_link_valid_i = '0;
        for (int l = 0; l < event_pkg::NUM_LINKS; l++) s_link_beat_i[l] = '0;
        m_ev_ready_i   = 1'b1;
        apb_i          = '0;
        repeat (2) @(posedge aclk);
        #2;
        arst_n_i = 1'b1;
        @(posedge aclk);
        #2;

        start_test("register access");
        expect_equal("s_link_ready_o", 32'(s_link_ready_o), 32'hf);
        expect_equal("m_ev_valid_o", 32'(m_ev_valid_o), 32'h0);
        write_reg(event_pkg::REG_MASK, 32'h0000_000a);
        expect_reg("REG_MASK", event_pkg::REG_MASK, 32'ha);
        expect_reg("REG_EVENTS", event_pkg::REG_EVENTS, 32'h0);
        expect_reg("REG_DROPPED", event_pkg::REG_DROPPED, 32'h0);
        read_reg(8'h0c, rdata, rerr);
        expect_equal("apb_o.pslverr", 32'(rerr), 32'h1);
        expect_equal("apb_o.prdata", rdata, 32'h0);
        finish_test();

        start_test("closed window");
        for (int n = 0; n < 3; n++) begin
            for (int l = 0; l < event_pkg::NUM_LINKS; l++) begin
                s_link_beat_i[l].tdata = $urandom;
                s_link_beat_i[l].tlast = (n == 2);
            end
            s_link_valid_i = '1;
            @(negedge aclk);
            expect_equal("s_link_ready_o", 32'(s_link_ready_o), 32'hf);
            @(posedge aclk);
            #2;
        end
        s_link_valid_i = '0;
        drop_exp += 3 * event_pkg::NUM_LINKS;
        repeat (8) @(posedge aclk);
        #2;
        expect_equal("evin_ready_o", 32'(evin_ready_o), 32'h0);
        expect_reg("REG_DROPPED", event_pkg::REG_DROPPED, 32'(drop_exp));
        finish_test();

        start_test("full event");
        run_events(1, 4'h0);
        expect_reg("REG_EVENTS", event_pkg::REG_EVENTS, 32'h1);
        finish_test();

        start_test("masked links");
        run_events(1, 4'ha);
        expect_reg("REG_DROPPED", event_pkg::REG_DROPPED, 32'(drop_exp));
        expect_reg("REG_EVENTS", event_pkg::REG_EVENTS, 32'h2);
        finish_test();

        start_test("back-pressure and pipelining");
        rand_ready = 1'b1;
        run_events(5, 4'h0);
        rand_ready = 1'b0;
        expect_reg("REG_EVENTS", event_pkg::REG_EVENTS, 32'(ev_num));
        finish_test();

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== event_builder_top.f ====
+incdir+verif
hdl/event_pkg.sv
hdl/event_regs.sv
hdl/link_accumulator.sv
hdl/completion_tracker.sv
hdl/event_readout.sv
hdl/event_builder_top.sv
verif/event_builder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the event builder testbench with Verilator, run it, then scan the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir --top-module event_builder_tb \
    -f event_builder_top.f -o sim_event_builder \
    && ./obj_dir/sim_event_builder | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "SIMULATION FAILED" sim.log && { echo "failure reported in sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "sim.log holds no pass report"; exit 1; }
echo "run_sim: ok"
